//--- include/eeprom_ctrl_config.svh
//********************
// eeprom controller configuration
// clock rates, scl divider and slave address
//********************
`ifndef EEPROM_CTRL_CONFIG_SVH
`define EEPROM_CTRL_CONFIG_SVH

// system clock in hz
`define SYS_CLK_HZ 125_000_000

// i2c bus rate in hz
`define SCL_HZ 1_250_000

// system clocks per scl bit, must stay a multiple of 4
`define SCL_DIV (`SYS_CLK_HZ / `SCL_HZ)

// 7-bit slave address of the eeprom
`define DEVICE_ID 7'b1010_100

`endif

//--- hdl/i2c_pkg.sv
//********************
// i2c bus-level types
// engine command flags, engine states, address byte
//********************
package i2c_pkg;

	// command flags, any mix per command
	typedef struct packed {
		logic nack;	// master answers the read byte with nack
		logic stop;
		logic read;
		logic write;
		logic start;
	} cmd_t;

	// byte engine states, one-hot
	typedef enum logic [6:0] {
		st_idle    = 7'b000_0001,
		st_start   = 7'b000_0010,
		st_wr_data = 7'b000_0100,
		st_rd_data = 7'b000_1000,
		st_r_ack   = 7'b001_0000,	// slave acknowledge
		st_t_ack   = 7'b010_0000,	// master acknowledge
		st_stop    = 7'b100_0000
	} eng_state_t;

	typedef struct packed {
		logic [6:0] dev_id;
		logic       rw;	// 1 = read
	} addr_fields_t;

	// first byte after start, as shifted or as decoded
	typedef union packed {
		logic [7:0]   raw;
		addr_fields_t fields;
	} addr_byte_u;

endpackage

//--- hdl/eeprom_pkg.sv
//********************
// eeprom transaction-level types
//********************
package eeprom_pkg;

	// sequencer steps of one single-byte access
	typedef enum logic [2:0] {
		step_idle,
		step_dev_w,	// start + device address, write
		step_mem_addr,
		step_wr_byte,	// data byte + stop
		step_dev_r,	// repeated start + device address, read
		step_rd_byte,	// read with nack + stop
		step_finish
	} seq_step_t;

	// host request kind
	typedef enum logic {
		req_write = 1'b0,
		req_read  = 1'b1
	} req_kind_t;

endpackage

//--- hdl/i2c_bit_timer.sv
//********************
// i2c bit timer
// scl divider with quarter-period phase strobes
//********************
`timescale 1ns/1ps
`include "eeprom_ctrl_config.svh"

module i2c_bit_timer (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  logic run,
	output logic scl,
	output logic low_mid,
	output logic high_mid,
	output logic bit_end
);

localparam int scl_div = `SCL_DIV;
localparam int cnt_w   = $clog2(scl_div);

localparam logic [cnt_w-1:0] cnt_low_mid  = cnt_w'(scl_div / 4 - 1);
localparam logic [cnt_w-1:0] cnt_half     = cnt_w'(scl_div / 2 - 1);
localparam logic [cnt_w-1:0] cnt_high_mid = cnt_w'(scl_div * 3 / 4 - 1);
localparam logic [cnt_w-1:0] cnt_last     = cnt_w'(scl_div - 1);

logic [cnt_w-1:0] cnt;

// counter sits at zero while stopped, so no strobe fires then
assign low_mid  = (cnt == cnt_low_mid);	// sda may change
assign high_mid = (cnt == cnt_high_mid);	// sda is sampled
assign bit_end  = (cnt == cnt_last);

always_ff @(posedge sys_clk or negedge sys_rst_n) begin
	if (!sys_rst_n) begin
		cnt <= '0;
	end else if (!run || bit_end) begin
		cnt <= '0;
	end else begin
		cnt <= cnt + 1'b1;
	end
end

//********************
// scl level
//********************
// low in the first half of a bit, high in the second
always_ff @(posedge sys_clk or negedge sys_rst_n) begin
	if (!sys_rst_n) begin
		scl <= 1'b1;
	end else if (!run) begin
		scl <= 1'b1;	// parked high, bus free after stop
	end else if (bit_end) begin
		scl <= 1'b0;
	end else if (cnt == cnt_half) begin
		scl <= 1'b1;
	end
end

endmodule

//--- hdl/i2c_byte_engine.sv
//********************
// i2c byte engine
// master fsm for start, byte shift, acknowledge and stop
//********************
`timescale 1ns/1ps

module i2c_byte_engine (
	input  logic          sys_clk,
	input  logic          sys_rst_n,
	input  i2c_pkg::cmd_t cmd,
	input  logic          cmd_vld,
	input  logic [7:0]    tx_byte,
	input  logic          sda_in,
	input  logic          low_mid,
	input  logic          high_mid,
	input  logic          bit_end,
	output logic          run,
	output logic          sda_oe,
	output logic          done,
	output logic          rd_data_vld,
	output logic          rev_ack,
	output logic [7:0]    rd_data
);

i2c_pkg::eng_state_t cstate;
i2c_pkg::eng_state_t nstate;
i2c_pkg::cmd_t       cmd_r;
logic [7:0]          tx_byte_r;
logic [7:0]          rd_shift;
logic [2:0]          cnt_num;	// bit index inside a data byte
logic                is_data;
logic                end_num;
logic                stop_end;

assign is_data  = (cstate == i2c_pkg::st_wr_data) || (cstate == i2c_pkg::st_rd_data);
assign end_num  = bit_end && (!is_data || cnt_num == 3'd7);
assign stop_end = (cstate == i2c_pkg::st_stop) && end_num;

// timer runs from the command strobe on, and lets go in the last stop
// cycle so scl stays high after the stop edge
assign run = ((cstate != i2c_pkg::st_idle) && !stop_end) || cmd_vld;

assign done = stop_end || (end_num && !cmd_r.stop &&
	(cstate == i2c_pkg::st_r_ack || cstate == i2c_pkg::st_t_ack));
assign rd_data_vld = (cstate == i2c_pkg::st_t_ack) && end_num;
assign rd_data     = rd_shift;

always_ff @(posedge sys_clk or negedge sys_rst_n) begin
	if (!sys_rst_n) begin
		cmd_r <= '0;
	end else if (cmd_vld) begin
		cmd_r <= cmd;
	end
end

always_ff @(posedge sys_clk) begin
	if (cmd_vld) begin
		tx_byte_r <= tx_byte;
	end
end

always_ff @(posedge sys_clk or negedge sys_rst_n) begin
	if (!sys_rst_n) begin
		cnt_num <= 3'd0;
	end else if (is_data && bit_end) begin
		cnt_num <= cnt_num + 1'b1;	// wraps to 0 after bit 7
	end
end

//********************
// state machine
//********************
always_ff @(posedge sys_clk or negedge sys_rst_n) begin
	if (!sys_rst_n) begin
		cstate <= i2c_pkg::st_idle;
	end else begin
		cstate <= nstate;
	end
end

always_comb begin
	nstate = cstate;
	case (cstate)
		i2c_pkg::st_idle: begin
			if (cmd_vld) begin
				if (cmd.start) nstate = i2c_pkg::st_start;
				else if (cmd.write) nstate = i2c_pkg::st_wr_data;
				else if (cmd.read) nstate = i2c_pkg::st_rd_data;
				else if (cmd.stop) nstate = i2c_pkg::st_stop;
			end
		end
		i2c_pkg::st_start: begin
			if (end_num) begin
				if (cmd_r.write) nstate = i2c_pkg::st_wr_data;
				else if (cmd_r.read) nstate = i2c_pkg::st_rd_data;
				else nstate = i2c_pkg::st_stop;
			end
		end
		i2c_pkg::st_wr_data: if (end_num) nstate = i2c_pkg::st_r_ack;
		i2c_pkg::st_rd_data: if (end_num) nstate = i2c_pkg::st_t_ack;
		i2c_pkg::st_r_ack, i2c_pkg::st_t_ack: begin
			if (end_num) nstate = cmd_r.stop ? i2c_pkg::st_stop : i2c_pkg::st_idle;
		end
		i2c_pkg::st_stop: if (end_num) nstate = i2c_pkg::st_idle;
		default: nstate = i2c_pkg::st_idle;
	endcase
end

//********************
// sda drive
//********************
// sda_oe high pulls the line low
always_ff @(posedge sys_clk or negedge sys_rst_n) begin
	if (!sys_rst_n) begin
		sda_oe <= 1'b0;
	end else if (low_mid) begin
		case (cstate)
			i2c_pkg::st_start:   sda_oe <= 1'b0;	// line high before the start edge
			i2c_pkg::st_wr_data: sda_oe <= ~tx_byte_r[3'd7 - cnt_num];
			i2c_pkg::st_t_ack:   sda_oe <= ~cmd_r.nack;
			i2c_pkg::st_stop:    sda_oe <= 1'b1;
			i2c_pkg::st_rd_data, i2c_pkg::st_r_ack: sda_oe <= 1'b0;	// slave drives
			default: ;
		endcase
	end else if (high_mid) begin
		if (cstate == i2c_pkg::st_start) sda_oe <= 1'b1;	// start edge, scl high
		else if (cstate == i2c_pkg::st_stop) sda_oe <= 1'b0;	// stop edge
	end
end

// 1 on the line during the ack bit means no acknowledge
always_ff @(posedge sys_clk or negedge sys_rst_n) begin
	if (!sys_rst_n) begin
		rev_ack <= 1'b0;
	end else if (high_mid && cstate == i2c_pkg::st_r_ack) begin
		rev_ack <= sda_in;
	end
end

always_ff @(posedge sys_clk) begin
	if (high_mid && cstate == i2c_pkg::st_rd_data) begin
		rd_shift <= {rd_shift[6:0], sda_in};	// msb first
	end
end

endmodule

//--- hdl/eeprom_sequencer.sv
//********************
// eeprom sequencer
// host byte requests to engine command series
//********************
`timescale 1ns/1ps
`include "eeprom_ctrl_config.svh"

module eeprom_sequencer (
	input  logic          sys_clk,
	input  logic          sys_rst_n,
	input  logic          wr_req,
	input  logic          rd_req,
	input  logic [7:0]    mem_addr,
	input  logic [7:0]    wr_data,
	input  logic          done,
	input  logic          rd_data_vld,
	input  logic          rev_ack,
	input  logic [7:0]    eng_rd_data,
	output logic          busy,
	output i2c_pkg::cmd_t cmd,
	output logic          cmd_vld,
	output logic [7:0]    tx_byte,
	output logic [7:0]    rd_data,
	output logic          rd_vld,
	output logic          ack_err
);

localparam i2c_pkg::cmd_t cmd_dev =
	'{nack: 1'b0, stop: 1'b0, read: 1'b0, write: 1'b1, start: 1'b1};
localparam i2c_pkg::cmd_t cmd_wr =
	'{nack: 1'b0, stop: 1'b0, read: 1'b0, write: 1'b1, start: 1'b0};
localparam i2c_pkg::cmd_t cmd_wr_stop =
	'{nack: 1'b0, stop: 1'b1, read: 1'b0, write: 1'b1, start: 1'b0};
localparam i2c_pkg::cmd_t cmd_rd_last =
	'{nack: 1'b1, stop: 1'b1, read: 1'b1, write: 1'b0, start: 1'b0};
localparam i2c_pkg::cmd_t cmd_stop =
	'{nack: 1'b0, stop: 1'b1, read: 1'b0, write: 1'b0, start: 1'b0};

eeprom_pkg::seq_step_t step;
eeprom_pkg::req_kind_t kind;
logic                  err;	// missing ack seen, stop-only in flight
logic [7:0]            mem_addr_r;
logic [7:0]            wr_data_r;
logic                  accept;

// device address byte with the wanted rw bit
function automatic logic [7:0] dev_addr(input logic rw);
	i2c_pkg::addr_byte_u ab;
	ab.fields.dev_id = `DEVICE_ID;
	ab.fields.rw     = rw;
	return ab.raw;
endfunction

assign accept = (step == eeprom_pkg::step_idle) && (wr_req || rd_req);

always_ff @(posedge sys_clk) begin
	if (accept) begin
		mem_addr_r <= mem_addr;
		wr_data_r  <= wr_data;
	end
	if (rd_data_vld) rd_data <= eng_rd_data;
end

//********************
// step control
//********************
always_ff @(posedge sys_clk or negedge sys_rst_n) begin
	if (!sys_rst_n) begin
		step    <= eeprom_pkg::step_idle;
		kind    <= eeprom_pkg::req_write;
		err     <= 1'b0;
		busy    <= 1'b0;
		cmd     <= '0;
		cmd_vld <= 1'b0;
		tx_byte <= 8'd0;
		rd_vld  <= 1'b0;
		ack_err <= 1'b0;
	end else begin
		cmd_vld <= 1'b0;
		rd_vld  <= 1'b0;
		ack_err <= 1'b0;
		case (step)
			eeprom_pkg::step_idle: begin
				if (accept) begin
					kind    <= wr_req ? eeprom_pkg::req_write : eeprom_pkg::req_read;	// write wins
					err     <= 1'b0;
					busy    <= 1'b1;
					step    <= eeprom_pkg::step_dev_w;
					cmd     <= cmd_dev;
					cmd_vld <= 1'b1;
					tx_byte <= dev_addr(1'b0);
				end
			end
			eeprom_pkg::step_finish: begin
				busy    <= 1'b0;
				rd_vld  <= !err && (kind == eeprom_pkg::req_read);
				ack_err <= err;
				step    <= eeprom_pkg::step_idle;
			end
			default: begin
				if (done && err) begin
					step <= eeprom_pkg::step_finish;	// abort stop is out
				end else if (done && rev_ack && step != eeprom_pkg::step_rd_byte) begin
					err <= 1'b1;
					if (step == eeprom_pkg::step_wr_byte) begin
						step <= eeprom_pkg::step_finish;	// stop already sent
					end else begin
						cmd     <= cmd_stop;
						cmd_vld <= 1'b1;
					end
				end else if (done) begin
					case (step)
						eeprom_pkg::step_dev_w: begin
							step    <= eeprom_pkg::step_mem_addr;
							cmd     <= cmd_wr;
							cmd_vld <= 1'b1;
							tx_byte <= mem_addr_r;
						end
						eeprom_pkg::step_mem_addr: begin
							cmd_vld <= 1'b1;
							if (kind == eeprom_pkg::req_write) begin
								step    <= eeprom_pkg::step_wr_byte;
								cmd     <= cmd_wr_stop;
								tx_byte <= wr_data_r;
							end else begin
								step    <= eeprom_pkg::step_dev_r;
								cmd     <= cmd_dev;	// repeated start
								tx_byte <= dev_addr(1'b1);
							end
						end
						eeprom_pkg::step_dev_r: begin
							step    <= eeprom_pkg::step_rd_byte;
							cmd     <= cmd_rd_last;
							cmd_vld <= 1'b1;
						end
						default: step <= eeprom_pkg::step_finish;	// wr_byte, rd_byte
					endcase
				end
			end
		endcase
	end
end

endmodule

//--- hdl/eeprom_ctrl_top.sv
//********************
// eeprom controller top
// sequencer, byte engine and bit timer
//********************
`timescale 1ns/1ps

module eeprom_ctrl_top (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       wr_req,
	input  logic       rd_req,
	input  logic [7:0] mem_addr,
	input  logic [7:0] wr_data,
	input  logic       sda_in,
	output logic       busy,
	output logic [7:0] rd_data,
	output logic       rd_vld,
	output logic       ack_err,
	output logic       scl,
	output logic       sda_oe
);

i2c_pkg::cmd_t eng_cmd;
logic          eng_cmd_vld;
logic [7:0]    eng_byte;
logic          eng_done;
logic          eng_rd_data_vld;
logic          eng_rev_ack;
logic [7:0]    eng_rd_data;
logic          run;
logic          low_mid;
logic          high_mid;
logic          bit_end;

eeprom_sequencer eeprom_sequencer_i (
	.sys_clk     (sys_clk),
	.sys_rst_n   (sys_rst_n),
	.wr_req      (wr_req),
	.rd_req      (rd_req),
	.mem_addr    (mem_addr),
	.wr_data     (wr_data),
	.done        (eng_done),
	.rd_data_vld (eng_rd_data_vld),
	.rev_ack     (eng_rev_ack),
	.eng_rd_data (eng_rd_data),
	.busy        (busy),
	.cmd         (eng_cmd),
	.cmd_vld     (eng_cmd_vld),
	.tx_byte     (eng_byte),
	.rd_data     (rd_data),
	.rd_vld      (rd_vld),
	.ack_err     (ack_err)
);

i2c_byte_engine i2c_byte_engine_i (
	.sys_clk     (sys_clk),
	.sys_rst_n   (sys_rst_n),
	.cmd         (eng_cmd),
	.cmd_vld     (eng_cmd_vld),
	.tx_byte     (eng_byte),
	.sda_in      (sda_in),
	.low_mid     (low_mid),
	.high_mid    (high_mid),
	.bit_end     (bit_end),
	.run         (run),
	.sda_oe      (sda_oe),
	.done        (eng_done),
	.rd_data_vld (eng_rd_data_vld),
	.rev_ack     (eng_rev_ack),
	.rd_data     (eng_rd_data)
);

i2c_bit_timer i2c_bit_timer_i (
	.sys_clk   (sys_clk),
	.sys_rst_n (sys_rst_n),
	.run       (run),
	.scl       (scl),
	.low_mid   (low_mid),
	.high_mid  (high_mid),
	.bit_end   (bit_end)
);

endmodule

//--- testbench/eeprom_model.sv
//********************
// i2c slave eeprom model
// 256-byte memory, switchable acknowledge
//********************
`timescale 1ns/1ps
`include "eeprom_ctrl_config.svh"

module eeprom_model (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  logic scl,
	input  logic sda,
	input  logic ack_en,
	output logic sda_low	// pulls the shared line low
);

localparam int ph_idle = 0;
localparam int ph_dev  = 1;
localparam int ph_mem  = 2;
localparam int ph_wr   = 3;
localparam int ph_rd   = 4;

logic [7:0] mem [256];
logic       scl_d;
logic       sda_d;
int         phase;
int         bit_cnt;
logic [7:0] shift;
logic [7:0] ptr;	// internal address pointer
logic       in_ack;
logic       acked;
i2c_pkg::addr_byte_u ab;

initial begin
	for (int i = 0; i < 256; i++) mem[i] = 8'(i) ^ 8'hA5;
end

// bus sampled on the system clock, edges found against the last sample
always @(posedge sys_clk or negedge sys_rst_n) begin : slave
	logic start_det;
	logic stop_det;
	logic rise;
	logic fall;
	if (!sys_rst_n) begin
		scl_d   = 1'b1;
		sda_d   = 1'b1;
		phase   = ph_idle;
		bit_cnt = 0;
		in_ack  = 1'b0;
		acked   = 1'b0;
		ptr     = 8'd0;
		sda_low <= 1'b0;
	end else begin
		start_det = scl && scl_d && sda_d && !sda;
		stop_det  = scl && scl_d && !sda_d && sda;
		rise      = scl && !scl_d;
		fall      = !scl && scl_d;
		if (start_det) begin
			phase   = ph_dev;	// also a repeated start
			bit_cnt = 0;
			in_ack  = 1'b0;
			sda_low <= 1'b0;
		end else if (stop_det) begin
			phase   = ph_idle;
			in_ack  = 1'b0;
			sda_low <= 1'b0;
		end else if (rise && phase != ph_idle && phase != ph_rd && !in_ack && bit_cnt < 8) begin
			shift   = {shift[6:0], sda};	// msb first
			bit_cnt = bit_cnt + 1;
		end else if (fall && phase == ph_rd) begin
			if (bit_cnt < 8) begin
				sda_low <= !shift[7];
				shift   = {shift[6:0], 1'b0};
				bit_cnt = bit_cnt + 1;
			end else if (bit_cnt == 8) begin
				sda_low <= 1'b0;	// master acknowledge bit
				bit_cnt = 9;
			end else begin
				ptr   = ptr + 8'd1;
				phase = ph_idle;	// single reads only, nack expected
			end
		end else if (fall && phase != ph_idle) begin
			if (in_ack) begin
				in_ack  = 1'b0;
				bit_cnt = 0;
				sda_low <= 1'b0;
				if (!acked) begin
					phase = ph_idle;
				end else begin
					case (phase)
						ph_dev: begin
							if (ab.fields.rw) begin
								phase   = ph_rd;
								shift   = mem[ptr];
								sda_low <= !shift[7];
								shift   = {shift[6:0], 1'b0};
								bit_cnt = 1;
							end else begin
								phase = ph_mem;
							end
						end
						ph_mem: begin
							ptr   = shift;
							phase = ph_wr;
						end
						default: begin
							mem[ptr] = shift;
							ptr      = ptr + 8'd1;
						end
					endcase
				end
			end else if (bit_cnt == 8) begin
				ab.raw  = shift;
				acked   = ack_en && (phase != ph_dev || ab.fields.dev_id == `DEVICE_ID);
				in_ack  = 1'b1;
				sda_low <= acked;
			end
		end
		scl_d = scl;
		sda_d = sda;
	end
end

endmodule

//--- testbench/eeprom_checker.sv
//********************
// eeprom result checker
// shadow memory reference and per-transaction compare
//********************
`timescale 1ns/1ps

module eeprom_checker (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       wr_req,
	input  logic       rd_req,
	input  logic [7:0] mem_addr,
	input  logic [7:0] wr_data,
	input  logic       busy,
	input  logic [7:0] rd_data,
	input  logic       rd_vld,
	input  logic       ack_err,
	input  logic       ack_en,
	input  int         test_id,
	output int         err_cnt,
	output int         done_cnt,
	output logic       pending
);

logic [7:0] shadow [256];
int         errs  = 0;
int         dones = 0;
logic       pend  = 1'b0;
logic       busy_d = 1'b0;
eeprom_pkg::req_kind_t p_kind;
logic [7:0] p_addr;
logic [7:0] p_data;
logic       p_ack;
int         p_id;

assign err_cnt  = errs;
assign done_cnt = dones;
assign pending  = pend;

initial begin
	for (int i = 0; i < 256; i++) shadow[i] = 8'(i) ^ 8'hA5;
end

function automatic string label(input int id);
	case (id)
		1: return "read_unwritten";
		2: return "write_readback";
		3: return "random_ops";
		4: return "no_device_ack";
		5: return "busy_ignore";
		default: return "unnamed";
	endcase
endfunction

// expected read byte and error status of one request
function automatic void ref_result(input eeprom_pkg::req_kind_t kind, input logic [7:0] addr,
	input logic ack_ok, output logic [7:0] exp_data, output logic exp_err);
	exp_err  = !ack_ok;
	exp_data = (kind == eeprom_pkg::req_read) ? shadow[addr] : 8'h00;
endfunction

always @(posedge sys_clk) begin : compare
	logic [7:0] exp_data;
	logic       exp_err;
	logic       exp_rd;
	if (sys_rst_n) begin
		if ((rd_vld || ack_err) && !(busy_d && !busy)) begin
			errs++;
			$display("result pulse outside the end of a transaction (%s)", label(test_id));
		end
		if (busy_d && !busy) begin
			if (!pend) begin
				errs++;
				$display("transaction finished with no recorded request");
			end else begin
				ref_result(p_kind, p_addr, p_ack, exp_data, exp_err);
				exp_rd = !exp_err && (p_kind == eeprom_pkg::req_read);
				if (rd_vld !== exp_rd || ack_err !== exp_err) begin
					errs++;
					$display("FAILED %s: expected rd_vld %b ack_err %b, actual rd_vld %b ack_err %b",
						label(p_id), exp_rd, exp_err, rd_vld, ack_err);
				end else if (exp_rd && rd_data !== exp_data) begin
					errs++;
					$display("FAILED %s: addr %h expected %h, actual %h",
						label(p_id), p_addr, exp_data, rd_data);
				end
				if (!exp_err && p_kind == eeprom_pkg::req_write) shadow[p_addr] = p_data;
				pend = 1'b0;
				dones++;
			end
		end
		if (!busy && (wr_req || rd_req)) begin
			if (pend) begin
				errs++;
				$display("new request accepted while one is still open");
			end
			p_kind = wr_req ? eeprom_pkg::req_write : eeprom_pkg::req_read;	// write wins
			p_addr = mem_addr;
			p_data = wr_data;
			p_ack  = ack_en;
			p_id   = test_id;
			pend   = 1'b1;
		end
		busy_d = busy;
	end
end

endmodule

//--- testbench/eeprom_ctrl_assert.sv
//********************
// eeprom controller bus assertions
//********************
`timescale 1ns/1ps

module eeprom_ctrl_assert (
	input logic                sys_clk,
	input logic                sys_rst_n,
	input logic                scl,
	input logic                sda_oe,
	input i2c_pkg::eng_state_t eng_state,
	input logic                busy,
	input logic                rd_vld,
	input logic                ack_err
);

// with scl high only the start and stop edges move sda
sda_stable_high: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
	(sda_oe != $past(sda_oe) && $past(scl)) |->
		($past(eng_state) == i2c_pkg::st_start || $past(eng_state) == i2c_pkg::st_stop))
	else $error("sda changed with scl high outside a start or stop edge");

result_exclusive: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
	!(rd_vld && ack_err))
	else $error("rd_vld and ack_err high together");

result_at_end: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
	(rd_vld || ack_err) |-> ($past(busy) && !busy))
	else $error("result pulse without busy falling");

endmodule

bind eeprom_ctrl_top eeprom_ctrl_assert eeprom_ctrl_assert_i (
	.sys_clk   (sys_clk),
	.sys_rst_n (sys_rst_n),
	.scl       (scl),
	.sda_oe    (sda_oe),
	.eng_state (i2c_byte_engine_i.cstate),
	.busy      (busy),
	.rd_vld    (rd_vld),
	.ack_err   (ack_err)
);

//--- testbench/eeprom_ctrl_tb.sv
//********************
// eeprom controller testbench
// clock, reset, requests, bus wire and final report
//********************
`timescale 1ns/1ps

module eeprom_ctrl_tb;

localparam int n_trans    = 30;	// transactions issued below rounded up
localparam int max_cycles = n_trans * 4200 * 2;

logic       sys_clk = 1'b0;
logic       sys_rst_n;
logic       wr_req;
logic       rd_req;
logic [7:0] mem_addr;
logic [7:0] wr_data;
logic       busy;
logic [7:0] rd_data;
logic       rd_vld;
logic       ack_err;
logic       scl;
logic       sda_oe;
logic       sda_low;
logic       sda_line;
logic       ack_en;
int         test_id;
int         chk_errs;
int         chk_done;
logic       chk_pending;
int         tb_errs   = 0;
int         issued    = 0;
int         cycle_cnt = 0;
int         seed      = 91;

assign sda_line = !(sda_oe || sda_low);	// open-drain wire with pull-up

always #4 sys_clk = ~sys_clk;

eeprom_ctrl_top eeprom_ctrl_top_i (
	.sys_clk (sys_clk), .sys_rst_n (sys_rst_n), .wr_req (wr_req), .rd_req (rd_req),
	.mem_addr (mem_addr), .wr_data (wr_data), .sda_in (sda_line), .busy (busy),
	.rd_data (rd_data), .rd_vld (rd_vld), .ack_err (ack_err), .scl (scl), .sda_oe (sda_oe)
);

eeprom_model eeprom_model_i (
	.sys_clk (sys_clk), .sys_rst_n (sys_rst_n), .scl (scl), .sda (sda_line),
	.ack_en (ack_en), .sda_low (sda_low)
);

eeprom_checker eeprom_checker_i (
	.sys_clk (sys_clk), .sys_rst_n (sys_rst_n), .wr_req (wr_req), .rd_req (rd_req),
	.mem_addr (mem_addr), .wr_data (wr_data), .busy (busy), .rd_data (rd_data),
	.rd_vld (rd_vld), .ack_err (ack_err), .ack_en (ack_en), .test_id (test_id),
	.err_cnt (chk_errs), .done_cnt (chk_done), .pending (chk_pending)
);

always @(posedge sys_clk) begin
	cycle_cnt++;
	if (cycle_cnt >= max_cycles) begin
		$display("timeout after %0d cycles, a transaction never finished", cycle_cnt);
		$display("tests failed");
		$finish;
	end
end

task automatic check_bus_idle(input string where);
	if (scl !== 1'b1 || sda_oe !== 1'b0) begin
		tb_errs++;
		$display("FAILED bus_idle %s: expected scl 1 sda_oe 0, actual scl %b sda_oe %b",
			where, scl, sda_oe);
	end
endtask

task automatic pulse_request(input logic is_wr, input logic [7:0] addr, input logic [7:0] data);
	wr_req   = is_wr;
	rd_req   = !is_wr;
	mem_addr = addr;
	wr_data  = data;
	@(negedge sys_clk);
	wr_req = 1'b0;
	rd_req = 1'b0;
endtask

// waits for idle, pulses one request, then waits for busy to fall
task automatic issue(input logic is_wr, input logic [7:0] addr, input logic [7:0] data,
	input int id, input logic extra_pulse);
	while (busy) @(negedge sys_clk);
	test_id = id;
	pulse_request(is_wr, addr, data);
	issued++;
	if (!busy) begin
		tb_errs++;
		$display("request at addr %h was not accepted", addr);
	end
	if (extra_pulse) begin
		repeat (40) @(negedge sys_clk);
		pulse_request(1'b0, addr ^ 8'hFF, 8'h00);	// must be ignored
	end
	while (busy) @(negedge sys_clk);
	check_bus_idle("after transaction");
endtask

initial begin
	logic [7:0] addr;
	logic [7:0] data;
	logic       is_wr;
	sys_rst_n = 1'b0;
	wr_req    = 1'b0;
	rd_req    = 1'b0;
	mem_addr  = 8'd0;
	wr_data   = 8'd0;
	ack_en    = 1'b1;
	test_id   = 0;
	repeat (16) @(posedge sys_clk);
	@(negedge sys_clk);
	sys_rst_n = 1'b1;
	repeat (4) @(negedge sys_clk);
	check_bus_idle("after reset");

	issue(1'b0, 8'h5A, 8'h00, 1, 1'b0);
	issue(1'b0, 8'hC3, 8'h00, 1, 1'b0);

	addr = 8'h80 | 8'($random(seed) & 8'h3F);
	data = 8'($random(seed));
	issue(1'b1, addr, data, 2, 1'b0);
	issue(1'b0, addr, 8'h00, 2, 1'b0);

	// small address set so reads hit earlier writes and overwrite happens
	for (int n = 0; n < 20; n++) begin
		addr  = 8'h40 + 8'($random(seed) & 3);
		data  = 8'($random(seed));
		is_wr = 1'($random(seed) & 1);
		issue(is_wr, addr, data, 3, 1'b0);
	end

	@(negedge sys_clk);
	ack_en = 1'b0;
	issue(1'b1, 8'h10, 8'h3C, 4, 1'b0);
	issue(1'b0, 8'h10, 8'h00, 4, 1'b0);
	@(negedge sys_clk);
	ack_en = 1'b1;
	issue(1'b0, 8'h10, 8'h00, 4, 1'b0);	// memory unchanged

	issue(1'b0, 8'h41, 8'h00, 5, 1'b1);

	repeat (20) @(negedge sys_clk);
	if (chk_done != issued || chk_pending) begin
		tb_errs++;
		$display("result count mismatch: %0d requests, %0d finished, open %b",
			issued, chk_done, chk_pending);
	end
	$display("errors: checker %0d, testbench %0d", chk_errs, tb_errs);
	if (chk_errs == 0 && tb_errs == 0) begin
		$display("all tests passed");
	end else begin
		$display("tests failed");
	end
	$finish;
end

endmodule

//--- eeprom_ctrl.f
+incdir+include
hdl/i2c_pkg.sv
hdl/eeprom_pkg.sv
hdl/i2c_bit_timer.sv
hdl/i2c_byte_engine.sv
hdl/eeprom_sequencer.sv
hdl/eeprom_ctrl_top.sv
testbench/eeprom_model.sv
testbench/eeprom_checker.sv
testbench/eeprom_ctrl_assert.sv
testbench/eeprom_ctrl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the eeprom controller testbench with verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f eeprom_ctrl.f --top-module eeprom_ctrl_tb \
	-Mdir obj_dir -o eeprom_ctrl_sim \
	&& ./obj_dir/eeprom_ctrl_sim 2>&1 | tee sim.log \
	&& ! grep -q "tests failed" sim.log \
	&& echo "simulation PASS" \
	|| { echo "simulation FAIL"; exit 1; }
